//--- hdl/apuRegsPkg.sv
// CPU-side register map of the reduced APU
// Only the two pulse channels and the $4015/$4017 control registers exist
`default_nettype none

package apuRegsPkg;

  typedef logic [4:0] apuAddrT;   // Offset from $4000
  typedef logic [7:0] apuDataT;
  typedef logic [1:0] regSelT;    // Register inside one channel

  // ----------------------------------------
  // Register offsets
  // ----------------------------------------
  localparam apuAddrT Pulse1Base    = 5'h00;
  localparam apuAddrT Pulse2Base    = 5'h04;
  localparam apuAddrT StatusAddr    = 5'h15;   // Enable on write, status on read
  localparam apuAddrT FrameCtrlAddr = 5'h17;

  // Pulse channel registers
  // Register 1 held the sweep unit and is ignored
  localparam regSelT DutyEnvReg  = 2'd0;
  localparam regSelT PeriodLoReg = 2'd2;
  localparam regSelT PeriodHiReg = 2'd3;   // Also length index and restart

  // ----------------------------------------
  // Bit positions
  // ----------------------------------------
  localparam int Pulse1LenBit = 0;   // Status and enable
  localparam int Pulse2LenBit = 1;
  localparam int FrameIrqBit  = 6;

  // Frame control fields
  localparam int FrameModeBit  = 7;   // 1 selects the 5-step sequence
  localparam int IrqInhibitBit = 6;

endpackage

`default_nettype wire

//--- hdl/apuChanPkg.sv
// Channel-side types and lookup functions shared by the pulse channels
// Length table values are the full counts as loaded into the counter
`default_nettype none

package apuChanPkg;

  typedef logic [7:0]  lengthT;
  typedef logic [10:0] periodT;
  typedef logic [3:0]  volumeT;   // Volume or envelope level
  typedef logic [3:0]  sampleT;
  typedef logic [4:0]  mixT;      // Sum of two channels
  typedef logic [1:0]  dutyT;
  typedef logic [2:0]  seqPosT;

  // Periods below this are ultrasonic and muted
  localparam periodT MinPeriod = 11'd8;

  typedef enum logic {
    FourStep,
    FiveStep
  } frameModeT;

  // Length counter load values
  function automatic lengthT lengthLookup(input logic [4:0] index);
    lengthT count;
    if (index[0]) begin
      // Odd entries count linearly except the first
      count = (index == 5'd1) ? 8'd254 : lengthT'(index - 5'd1);
    end else begin
      case (index[4:1])
        4'd0:    count = 8'd10;
        4'd1:    count = 8'd20;
        4'd2:    count = 8'd40;
        4'd3:    count = 8'd80;
        4'd4:    count = 8'd160;
        4'd5:    count = 8'd60;
        4'd6:    count = 8'd14;
        4'd7:    count = 8'd26;
        4'd8:    count = 8'd12;
        4'd9:    count = 8'd24;
        4'd10:   count = 8'd48;
        4'd11:   count = 8'd96;
        4'd12:   count = 8'd192;
        4'd13:   count = 8'd72;
        4'd14:   count = 8'd16;
        default: count = 8'd32;
      endcase
    end
    return count;
  endfunction

  // High phase of the duty waveform at a given step
  function automatic logic dutyActive(input dutyT duty, input seqPosT pos);
    logic active;
    case (duty)
      2'd0:    active = (pos == 3'd7);   // 12.5 %
      2'd1:    active = (pos >= 3'd6);   // 25 %
      2'd2:    active = (pos >= 3'd4);   // 50 %
      default: active = (pos < 3'd6);    // 75 %
    endcase
    return active;
  endfunction

endpackage

`default_nettype wire

//--- hdl/frameSequencer.sv
// Frame step counter with evenly spaced steps of QuarterCycles enabled cycles
// Pulses hold until the next enabled cycle so consumers qualify them with ce
`timescale 1ns/1ps
`default_nettype none

module frameSequencer #(
  parameter int QuarterCycles = 7457
) (
  input  wire logic                 clk,
  input  wire logic                 reset,
  input  wire logic                 ce,
  input  wire logic                 frameWrite,
  input  wire apuRegsPkg::apuDataT  dataIn,
  input  wire logic                 statusRead,
  output logic                      quarterFrame,
  output logic                      halfFrame,
  output logic                      frameIrq
);

  localparam int MaxCount = 5 * QuarterCycles;
  localparam int CountW   = $clog2(MaxCount + 1);

  typedef logic [CountW-1:0] countT;

  localparam countT Step1 = countT'(QuarterCycles);
  localparam countT Step2 = countT'(2 * QuarterCycles);
  localparam countT Step3 = countT'(3 * QuarterCycles);
  localparam countT Step4 = countT'(4 * QuarterCycles);
  localparam countT Step5 = countT'(MaxCount);

  countT                 count;
  apuChanPkg::frameModeT mode;
  logic                  inhibit;

  logic quarterHit;
  logic halfHit;
  logic lastHit;    // Final step of the sequence
  logic irqHit;

  // ----------------------------------------
  // Step decode
  // ----------------------------------------
  always_comb begin
    quarterHit = 1'b0;
    halfHit    = 1'b0;
    lastHit    = 1'b0;
    if (count == Step1 || count == Step3) begin
      quarterHit = 1'b1;
    end else if (count == Step2) begin
      quarterHit = 1'b1;
      halfHit    = 1'b1;
    end else if (count == Step4 && mode == apuChanPkg::FourStep) begin
      quarterHit = 1'b1;
      halfHit    = 1'b1;
      lastHit    = 1'b1;
    end else if (count == Step5) begin
      quarterHit = 1'b1;                 // Only reached in 5-step mode
      halfHit    = 1'b1;
      lastHit    = 1'b1;
    end
  end

  assign irqHit = lastHit && (mode == apuChanPkg::FourStep) && !inhibit;

  // ----------------------------------------
  // Counter, mode and interrupt flag
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      count        <= '0;
      mode         <= apuChanPkg::FourStep;
      inhibit      <= 1'b0;
      quarterFrame <= 1'b0;
      halfFrame    <= 1'b0;
      frameIrq     <= 1'b0;
    end else if (ce) begin
      if (frameWrite) begin
        count        <= '0;
        mode         <= dataIn[apuRegsPkg::FrameModeBit] ? apuChanPkg::FiveStep
                                                         : apuChanPkg::FourStep;
        inhibit      <= dataIn[apuRegsPkg::IrqInhibitBit];
        // 5-step mode clocks the channels right away
        quarterFrame <= dataIn[apuRegsPkg::FrameModeBit];
        halfFrame    <= dataIn[apuRegsPkg::FrameModeBit];
      end else begin
        count        <= lastHit ? '0 : count + countT'(1);
        quarterFrame <= quarterHit;
        halfFrame    <= halfHit;
      end

      if (frameWrite && dataIn[apuRegsPkg::IrqInhibitBit])
        frameIrq <= 1'b0;
      else if (irqHit)
        frameIrq <= 1'b1;                // Wins over a read in the same cycle
      else if (statusRead)
        frameIrq <= 1'b0;
    end
  end

  // Half-frame clocks always ride on a quarter-frame clock
  halfWithQuarter: assert property (
    @(posedge clk) disable iff (reset) halfFrame |-> quarterFrame
  );

endmodule

`default_nettype wire

//--- hdl/envelopeUnit.sv
// Envelope generator for one channel, clocked by qualified quarter-frame pulses
`timescale 1ns/1ps
`default_nettype none

module envelopeUnit (
  input  wire logic                clk,
  input  wire logic                reset,
  input  wire logic                quarterFrame,
  input  wire logic                restart,      // Held until the next quarter frame
  input  wire logic                loopEnable,
  input  wire apuChanPkg::volumeT  divPeriod,
  output apuChanPkg::volumeT       level
);

  localparam apuChanPkg::volumeT MaxLevel = 4'd15;

  apuChanPkg::volumeT divider;

  // Level falls once per divPeriod+1 quarter frames
  always_ff @(posedge clk) begin
    if (reset) begin
      divider <= '0;
      level   <= '0;
    end else if (quarterFrame) begin
      if (restart) begin
        level   <= MaxLevel;
        divider <= divPeriod;
      end else if (divider == '0) begin
        divider <= divPeriod;           // Divider expired
        if (level != '0)
          level <= level - 4'd1;
        else if (loopEnable)
          level <= MaxLevel;            // Sawtooth when looping
      end else begin
        divider <= divider - 4'd1;
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/pulseChannel.sv
// One pulse channel without sweep unit
// Periods below MinPeriod are muted and the timer steps on even CPU cycles only
`timescale 1ns/1ps
`default_nettype none

module pulseChannel (
  input  wire logic                 clk,
  input  wire logic                 reset,
  input  wire logic                 ce,
  input  wire logic                 oddCycle,
  input  wire logic                 regWrite,
  input  wire apuRegsPkg::regSelT   regSel,
  input  wire apuRegsPkg::apuDataT  dataIn,
  input  wire logic                 quarterFrame,
  input  wire logic                 halfFrame,
  input  wire logic                 enable,
  output apuChanPkg::sampleT        sample,
  output logic                      lengthActive
);

  // Register 0 payload
  apuChanPkg::dutyT   duty;
  logic               constVol;
  apuChanPkg::volumeT volume;     // Also the envelope divider period

  logic               haltLoop;   // Length halt and envelope loop share a bit
  apuChanPkg::periodT period;
  apuChanPkg::periodT timer;
  apuChanPkg::seqPosT seqPos;
  apuChanPkg::lengthT lengthCnt;
  logic               envRestart;

  logic               lengthLoad;
  logic               envClock;
  apuChanPkg::volumeT envLevel;
  logic               audible;

  assign lengthLoad = regWrite && (regSel == apuRegsPkg::PeriodHiReg);
  assign envClock   = ce && quarterFrame;

  always_ff @(posedge clk) begin
    if (ce && regWrite && regSel == apuRegsPkg::DutyEnvReg) begin
      duty     <= dataIn[7:6];
      constVol <= dataIn[4];
      volume   <= dataIn[3:0];
    end
  end

  // ----------------------------------------
  // Timer, sequencer and length counter
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      haltLoop   <= 1'b0;
      period     <= '0;
      timer      <= '0;
      seqPos     <= '0;
      lengthCnt  <= '0;
      envRestart <= 1'b0;
    end else if (ce) begin
      if (!oddCycle) begin
        if (timer == '0) begin
          timer  <= period;
          seqPos <= seqPos - 3'd1;   // Sequencer runs downward
        end else begin
          timer <= timer - 11'd1;
        end
      end

      if (regWrite) begin
        case (regSel)
          apuRegsPkg::DutyEnvReg:  haltLoop <= dataIn[5];
          apuRegsPkg::PeriodLoReg: period[7:0] <= dataIn;
          apuRegsPkg::PeriodHiReg: begin
            period[10:8] <= dataIn[2:0];
            seqPos       <= '0;           // Overrides a timer step
          end
          default: ;
        endcase
      end

      if (!enable)
        lengthCnt <= '0;
      else if (lengthLoad)
        lengthCnt <= apuChanPkg::lengthLookup(dataIn[7:3]);
      else if (halfFrame && lengthCnt != '0 && !haltLoop)
        lengthCnt <= lengthCnt - 8'd1;

      // Restart request waits for the next quarter frame
      if (lengthLoad)
        envRestart <= 1'b1;
      else if (quarterFrame)
        envRestart <= 1'b0;
    end
  end

  envelopeUnit env_i (
    .clk          (clk),
    .reset        (reset),
    .quarterFrame (envClock),
    .restart      (envRestart),
    .loopEnable   (haltLoop),
    .divPeriod    (volume),
    .level        (envLevel)
  );

  // Output gating
  assign audible = (lengthCnt != '0) && (period >= apuChanPkg::MinPeriod)
                   && apuChanPkg::dutyActive(duty, seqPos);
  assign sample       = audible ? (constVol ? volume : envLevel) : '0;
  assign lengthActive = (lengthCnt != '0);

  // A disabled channel loses its length and is silent from the next cycle
  disabledSilent: assert property (
    @(posedge clk) disable iff (reset) (ce && !enable) |=> (sample == '0)
  );

endmodule

`default_nettype wire

//--- hdl/nesApu.sv
// Reduced APU with two pulse channels and the frame sequencer
// The sample is the plain 5-bit sum of both channels without a mixer table
`timescale 1ns/1ps
`default_nettype none

module nesApu #(
  parameter int QuarterCycles = 7457
) (
  input  wire logic                 clk,
  input  wire logic                 reset,
  input  wire logic                 ce,        // CPU cycle enable
  input  wire logic                 oddCycle,
  input  wire apuRegsPkg::apuAddrT  addr,
  input  wire apuRegsPkg::apuDataT  dataIn,
  input  wire logic                 write,
  input  wire logic                 read,
  output apuRegsPkg::apuDataT       dataOut,
  output logic                      irq,
  output apuChanPkg::mixT           sample
);

  logic pulse1Write;
  logic pulse2Write;
  logic frameWrite;
  logic statusWrite;
  logic statusRead;

  logic [1:0] chanEnable;

  logic               quarterFrame;
  logic               halfFrame;
  logic               frameIrq;
  apuChanPkg::sampleT sample1;
  apuChanPkg::sampleT sample2;
  logic               lenActive1;
  logic               lenActive2;

  // ----------------------------------------
  // Address decode
  // ----------------------------------------
  assign pulse1Write = write && (addr[4:2] == apuRegsPkg::Pulse1Base[4:2]);
  assign pulse2Write = write && (addr[4:2] == apuRegsPkg::Pulse2Base[4:2]);
  assign frameWrite  = write && (addr == apuRegsPkg::FrameCtrlAddr);
  assign statusWrite = write && (addr == apuRegsPkg::StatusAddr);
  assign statusRead  = read && (addr == apuRegsPkg::StatusAddr);

  always_ff @(posedge clk) begin
    if (reset)
      chanEnable <= '0;
    else if (ce && statusWrite)
      chanEnable <= {dataIn[apuRegsPkg::Pulse2LenBit], dataIn[apuRegsPkg::Pulse1LenBit]};
  end

  frameSequencer #(
    .QuarterCycles (QuarterCycles)
  ) frameSeq_i (
    .clk          (clk),
    .reset        (reset),
    .ce           (ce),
    .frameWrite   (frameWrite),
    .dataIn       (dataIn),
    .statusRead   (statusRead),
    .quarterFrame (quarterFrame),
    .halfFrame    (halfFrame),
    .frameIrq     (frameIrq)
  );

  pulseChannel pulse1_i (
    .clk          (clk),
    .reset        (reset),
    .ce           (ce),
    .oddCycle     (oddCycle),
    .regWrite     (pulse1Write),
    .regSel       (addr[1:0]),
    .dataIn       (dataIn),
    .quarterFrame (quarterFrame),
    .halfFrame    (halfFrame),
    .enable       (chanEnable[0]),
    .sample       (sample1),
    .lengthActive (lenActive1)
  );

  pulseChannel pulse2_i (
    .clk          (clk),
    .reset        (reset),
    .ce           (ce),
    .oddCycle     (oddCycle),
    .regWrite     (pulse2Write),
    .regSel       (addr[1:0]),
    .dataIn       (dataIn),
    .quarterFrame (quarterFrame),
    .halfFrame    (halfFrame),
    .enable       (chanEnable[1]),
    .sample       (sample2),
    .lengthActive (lenActive2)
  );

  // Status read shows the flag even in the cycle that clears it
  always_comb begin
    dataOut                           = '0;
    dataOut[apuRegsPkg::Pulse1LenBit] = lenActive1;
    dataOut[apuRegsPkg::Pulse2LenBit] = lenActive2;
    dataOut[apuRegsPkg::FrameIrqBit]  = frameIrq;
  end

  assign irq    = frameIrq;
  assign sample = apuChanPkg::mixT'(sample1) + apuChanPkg::mixT'(sample2);

  // Disabling pulse 1 clears its status bit after one more enabled cycle
  statusFollowsEnable: assert property (
    @(posedge clk) disable iff (reset)
      (ce && statusWrite && !dataIn[apuRegsPkg::Pulse1LenBit]) ##1 ce
      |=> !dataOut[apuRegsPkg::Pulse1LenBit]
  );

endmodule

`default_nettype wire

//--- tb/apuRefModel.svh
// Testbench reference model for the pulse channel rules
// Included inside the testbench module, so it holds functions only
`ifndef APU_REF_MODEL_SVH
`define APU_REF_MODEL_SVH

// Length counter load value for a 5-bit index
function automatic int refLength(input int index);
  int lengths [32] = '{10, 254, 20,  2, 40,  4, 80,  6,
                       160,  8, 60, 10, 14, 12, 26, 14,
                       12,  16, 24, 18, 48, 20, 96, 22,
                       192, 24, 72, 26, 16, 28, 32, 30};
  return lengths[index];
endfunction

// Duty waveform, bit p is the output at sequencer step p
function automatic bit refDuty(input int duty, input int pos);
  bit [7:0] pattern [4] = '{8'b1000_0000, 8'b1100_0000, 8'b1111_0000, 8'b0011_1111};
  return pattern[duty][pos];
endfunction

// Envelope level after n quarter frames counted from the restart
function automatic int refEnvLevel(input int n, input int divPeriod, input bit loopOn);
  int drops;
  drops = n / (divPeriod + 1);
  if (loopOn)
    return (15 - drops) & 15;   // Sawtooth
  else if (drops >= 15)
    return 0;
  else
    return 15 - drops;
endfunction

`endif

//--- tb/nesApuTb.sv
// Testbench for the reduced APU with a short frame step of 64 cycles
// ce is held high, so every cycle is an enabled cycle
`timescale 1ns/1ps
`default_nettype none

module nesApuTb;

  `include "apuRefModel.svh"

  localparam int QuarterCycles = 64;
  localparam int TimeoutCycles = 60000;   // Longest length test plus margin
  localparam int StepCycles    = 2 * (8 + 1);   // One sequencer step at period 8

  logic                 clk;
  logic                 reset;
  logic                 ce;
  logic                 oddCycle;
  apuRegsPkg::apuAddrT  addr;
  apuRegsPkg::apuDataT  dataIn;
  logic                 write;
  logic                 read;
  apuRegsPkg::apuDataT  dataOut;
  logic                 irq;
  apuChanPkg::mixT      sample;

  int               cycles;
  logic             mixCheckOn;
  logic             seenDouble;
  apuChanPkg::mixT  mixVol;

  nesApu #(.QuarterCycles(QuarterCycles)) dut_i (
    .clk (clk), .reset (reset), .ce (ce), .oddCycle (oddCycle),
    .addr (addr), .dataIn (dataIn), .write (write), .read (read),
    .dataOut (dataOut), .irq (irq), .sample (sample)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) #1 oddCycle <= ~oddCycle;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TimeoutCycles) begin
      $display("Timeout after %0d cycles, the test sequence did not complete", cycles);
      $display("Finished with errors");
      $fatal(1);
    end
  end

  // ----------------------------------------
  // Checks
  // ----------------------------------------
  task automatic failRun(input string why);
    $display("%s", why);
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic checkData(input string name, input apuRegsPkg::apuDataT exp,
                           input apuRegsPkg::apuDataT act);
    if (exp !== act)
      failRun($sformatf("ERROR %s expected 0x%02h actual 0x%02h", name, exp, act));
  endtask

  task automatic checkSample(input string name, input apuChanPkg::mixT exp,
                             input apuChanPkg::mixT act);
    if (exp !== act)
      failRun($sformatf("ERROR %s expected %0d actual %0d", name, exp, act));
  endtask

  task automatic checkIrq(input string name, input bit exp, input logic act);
    if (exp !== act)
      failRun($sformatf("ERROR %s expected %0b actual %0b", name, exp, act));
  endtask

  task automatic checkCount(input string name, input int exp, input int act);
    if (exp != act)
      failRun($sformatf("ERROR %s expected %0d actual %0d", name, exp, act));
  endtask

  // Sample must be 0, V or 2V while two equal channels play
  always @(negedge clk) begin
    if (mixCheckOn) begin
      if (sample !== 0 && sample !== mixVol && sample !== 2 * mixVol)
        failRun($sformatf("Sample %0d is not 0, %0d or %0d", sample, mixVol, 2 * mixVol));
      if (sample === 2 * mixVol)
        seenDouble = 1'b1;
    end
  end

  // ----------------------------------------
  // Bus access, called 1 ns after a rising edge
  // ----------------------------------------
  task automatic busWrite(input apuRegsPkg::apuAddrT a, input apuRegsPkg::apuDataT d);
    addr   = a;
    dataIn = d;
    write  = 1'b1;
    @(posedge clk);
    #1;
    write  = 1'b0;
  endtask

  task automatic statusRead();
    addr = apuRegsPkg::StatusAddr;
    read = 1'b1;
    @(posedge clk);
    #1;
    read = 1'b0;
  endtask

  task automatic configPulse(input apuRegsPkg::apuAddrT base, input int duty, input bit halt,
                             input bit constVol, input int vol, input int period,
                             input int lenIdx);
    busWrite(base, {duty[1:0], halt, constVol, vol[3:0]});
    busWrite(base + 5'd2, period[7:0]);
    busWrite(base + 5'd3, {lenIdx[4:0], period[10:8]});
  endtask

  task automatic waitQuarter();
    do @(negedge clk); while (!dut_i.quarterFrame);
  endtask

  task automatic irqStaysLow(input string name, input int count);
    repeat (count) begin
      @(negedge clk);
      checkIrq(name, 1'b0, irq);
    end
    @(posedge clk);
    #1;
  endtask

  // Peak sample per quarter-frame interval against the decay rule
  task automatic envelopeRun(input int divPeriod, input bit loopOn, input int intervals);
    apuChanPkg::mixT peak;
    configPulse(apuRegsPkg::Pulse1Base, 3, loopOn, 1'b0, divPeriod, 8, 8);
    waitQuarter();                       // Restart takes effect here
    for (int n = 0; n < intervals; n++) begin
      peak = '0;
      do begin
        @(negedge clk);
        if (sample > peak)
          peak = sample;
      end while (!dut_i.quarterFrame);
      checkSample("envelopeDecay", apuChanPkg::mixT'(refEnvLevel(n, divPeriod, loopOn)), peak);
    end
    @(posedge clk);
    #1;
  endtask

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial begin
    int idx;
    int len;
    int halves;
    int quarters;
    int waited;
    int highSteps;
    int highs;
    void'($urandom(32'h7330));
    reset      = 1'b1;
    ce         = 1'b1;
    oddCycle   = 1'b0;
    addr       = '0;
    dataIn     = '0;
    write      = 1'b0;
    read       = 1'b0;
    cycles     = 0;
    mixCheckOn = 1'b0;
    seenDouble = 1'b0;
    mixVol     = '0;
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;

    // Length load and expiry
    busWrite(apuRegsPkg::FrameCtrlAddr, 8'h40);
    busWrite(apuRegsPkg::StatusAddr, 8'h01);
    do idx = $urandom % 32; while (refLength(idx) > 48);
    configPulse(apuRegsPkg::Pulse1Base, 2, 1'b0, 1'b1, 5, 100, idx);
    len    = refLength(idx);
    halves = 0;
    while (halves < len) begin
      @(negedge clk);
      checkData("lengthHold", 8'h01, dataOut & 8'h01);
      if (dut_i.halfFrame)
        halves++;
    end
    waitQuarter();
    checkData("lengthExpired", 8'h00, dataOut & 8'h01);
    @(posedge clk);
    #1;

    // Halt, then disable
    configPulse(apuRegsPkg::Pulse1Base, 2, 1'b1, 1'b1, 5, 100, 3);   // Index 3 loads 2
    quarters = 0;
    while (quarters < 12) begin
      @(negedge clk);
      checkData("haltHold", 8'h01, dataOut & 8'h01);
      if (dut_i.quarterFrame)
        quarters++;
    end
    @(posedge clk);
    #1;
    busWrite(apuRegsPkg::StatusAddr, 8'h00);
    @(posedge clk);
    @(negedge clk);
    checkData("disabledStatus", 8'h00, dataOut & 8'h01);
    @(posedge clk);
    #1;

    // Frame interrupt
    busWrite(apuRegsPkg::FrameCtrlAddr, 8'h00);
    waited = 0;
    while (irq !== 1'b1 && waited < 4 * QuarterCycles + 2) begin
      @(negedge clk);
      waited++;
    end
    checkIrq("irqRaised", 1'b1, irq);
    checkData("irqStatus", 8'h40, dataOut & 8'h40);
    @(posedge clk);
    #1;
    statusRead();
    @(negedge clk);
    checkIrq("irqClearedByRead", 1'b0, irq);
    @(posedge clk);
    #1;
    busWrite(apuRegsPkg::FrameCtrlAddr, 8'h40);
    irqStaysLow("irqInhibited", 8 * QuarterCycles + 8);
    busWrite(apuRegsPkg::FrameCtrlAddr, 8'h80);
    irqStaysLow("irqFiveStep", 10 * QuarterCycles + 8);

    // Sample gating
    busWrite(apuRegsPkg::StatusAddr, 8'h03);
    mixVol = apuChanPkg::mixT'(1 + $urandom % 7);
    configPulse(apuRegsPkg::Pulse1Base, 3, 1'b1, 1'b1, mixVol, 8, 0);
    configPulse(apuRegsPkg::Pulse2Base, 3, 1'b1, 1'b1, mixVol, 8, 0);
    checkData("bothActive", 8'h03, dataOut & 8'h03);
    mixCheckOn = 1'b1;
    repeat (600) @(negedge clk);
    mixCheckOn = 1'b0;
    if (!seenDouble)
      failRun("Both channels never played together, the doubled sample did not occur");
    @(posedge clk);
    #1;
    busWrite(apuRegsPkg::Pulse2Base + 5'd2, 8'h04);   // Period 4 mutes pulse 2
    busWrite(apuRegsPkg::StatusAddr, 8'h02);
    repeat (2) @(posedge clk);
    @(negedge clk);
    checkData("mutedStillActive", 8'h02, dataOut & 8'h03);
    repeat (300) begin
      @(negedge clk);
      checkSample("mutedAndDisabled", '0, sample);
    end
    @(posedge clk);
    #1;

    // Duty patterns counted over two full sequences of pulse 1
    busWrite(apuRegsPkg::StatusAddr, 8'h01);
    configPulse(apuRegsPkg::Pulse1Base, 0, 1'b1, 1'b1, 9, 8, 0);
    for (int d = 0; d < 4; d++) begin
      busWrite(apuRegsPkg::Pulse1Base, {d[1:0], 2'b11, 4'd9});
      highSteps = 0;
      for (int p = 0; p < 8; p++)
        highSteps += refDuty(d, p);
      highs = 0;
      repeat (16 * StepCycles) begin
        @(negedge clk);
        if (sample != 0)
          highs++;
      end
      checkCount("dutyCycle", 2 * StepCycles * highSteps, highs);
      @(posedge clk);
      #1;
    end

    // Envelope decay
    busWrite(apuRegsPkg::FrameCtrlAddr, 8'h40);
    busWrite(apuRegsPkg::StatusAddr, 8'h01);
    envelopeRun(1, 1'b0, 40);
    envelopeRun(0, 1'b1, 36);

    $display("Finished with no errors");
    $finish;
  end

endmodule

`default_nettype wire

//--- nesApu.f
+incdir+tb
hdl/apuRegsPkg.sv
hdl/apuChanPkg.sv
hdl/frameSequencer.sv
hdl/envelopeUnit.sv
hdl/pulseChannel.sv
hdl/nesApu.sv
tb/nesApuTb.sv

//--- Bender.yml
package:
  name: nesApu

sources:
  - hdl/apuRegsPkg.sv
  - hdl/apuChanPkg.sv
  - hdl/frameSequencer.sv
  - hdl/envelopeUnit.sv
  - hdl/pulseChannel.sv
  - hdl/nesApu.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/nesApuTb.sv
